//--- hdl/fp_wb_pkg.sv
// Shared widths, codes and types for the single-precision FPU writeback stage
`default_nettype none

package fp_wb_pkg;

    //////////////////////////////
    // Format widths

    // Single precision layout
    localparam int unsigned FLEN = 32;
    localparam int unsigned EXPO_WIDTH = 8;
    localparam int unsigned FRAC_WIDTH = 23;

    // All-ones exponent, infinity and NaN
    localparam int unsigned EXPO_MAX = 255;

    // Units sharing the one writeback group
    localparam int unsigned NUM_WB_UNITS = 4;

    //////////////////////////////
    // Vector types

    // Sign, exponent, fraction
    typedef logic [FLEN-1:0] fp_word_t;
    typedef logic [EXPO_WIDTH-1:0] expo_t;
    // Fraction, hidden bit not stored
    typedef logic [FRAC_WIDTH-1:0] frac_t;
    // Guard, round, sticky
    typedef logic [2:0] grs_t;
    // Left shift from leading-zero count
    typedef logic [4:0] shift_amt_t;
    typedef logic [2:0] rm_t;
    typedef logic [4:0] fflags_t;
    typedef logic [3:0] id_t;
    typedef logic [$clog2(NUM_WB_UNITS)-1:0] unit_sel_t;

    //////////////////////////////
    // Rounding modes

    // Same encoding as the frm field
    localparam rm_t RM_RNE = 3'd0;
    localparam rm_t RM_RTZ = 3'd1;
    localparam rm_t RM_RDN = 3'd2;
    localparam rm_t RM_RUP = 3'd3;
    localparam rm_t RM_RMM = 3'd4;

    //////////////////////////////
    // Exception flag positions

    // Invalid, div by zero, overflow, underflow, inexact
    localparam int unsigned FLAG_NV = 4;
    localparam int unsigned FLAG_DZ = 3;
    localparam int unsigned FLAG_OF = 2;
    localparam int unsigned FLAG_UF = 1;
    localparam int unsigned FLAG_NX = 0;

endpackage

`default_nettype wire

//--- hdl/fp_wb_arbiter.sv
// Fixed-priority unit select with same-cycle ack and the stage-1 register
`timescale 1ns/1ps
`default_nettype none

module fp_wb_arbiter import fp_wb_pkg::*; (
    input  logic clk,
    input  logic rst,
    // Unit side, one entry per unit
    input  logic [NUM_WB_UNITS-1:0] unit_done,
    input  id_t unit_id [NUM_WB_UNITS],
    input  fp_word_t unit_rd [NUM_WB_UNITS],
    input  rm_t unit_rm [NUM_WB_UNITS],
    input  fflags_t unit_fflags [NUM_WB_UNITS],
    input  shift_amt_t unit_clz [NUM_WB_UNITS],
    input  logic unit_carry [NUM_WB_UNITS],
    input  logic unit_hidden [NUM_WB_UNITS],
    input  logic unit_safe [NUM_WB_UNITS],
    input  grs_t unit_grs [NUM_WB_UNITS],
    output logic [NUM_WB_UNITS-1:0] unit_ack,
    // Stage-1 fields toward normalization
    output logic norm_valid,
    output id_t norm_id,
    output fp_word_t norm_data,
    output rm_t norm_rm,
    output fflags_t norm_fflags,
    output shift_amt_t norm_clz,
    output logic norm_carry,
    output logic norm_hidden,
    output logic norm_safe,
    output grs_t norm_grs
);

    unit_sel_t unit_sel;
    logic any_done;

    //////////////////////////////
    // Priority select

    // Lowest unit index wins
    always_comb begin
        unit_sel = '0;
        for (int i = NUM_WB_UNITS - 1; i >= 0; i--) begin
            if (unit_done[i]) begin
                unit_sel = unit_sel_t'(i);
            end
        end
    end

    assign any_done = |unit_done;

    // One-hot ack, combinational in the done cycle
    always_comb begin
        unit_ack = '0;
        unit_ack[unit_sel] = any_done;
    end

    //////////////////////////////
    // Stage-1 register

    // Valid only control bit here
    always_ff @(posedge clk) begin
        if (rst) begin
            norm_valid <= 1'b0;
        end else begin
            norm_valid <= any_done;
        end
    end

    // Payload of the acked unit
    always_ff @(posedge clk) begin
        norm_id <= unit_id[unit_sel];
        norm_data <= unit_rd[unit_sel];
        norm_rm <= unit_rm[unit_sel];
        norm_fflags <= unit_fflags[unit_sel];
        // Normalization hints
        norm_clz <= unit_clz[unit_sel];
        norm_carry <= unit_carry[unit_sel];
        norm_hidden <= unit_hidden[unit_sel];
        norm_safe <= unit_safe[unit_sel];
        norm_grs <= unit_grs[unit_sel];
    end

endmodule

`default_nettype wire

//--- hdl/fp_normalize.sv
// Normalizes an unrounded result by carry right shift or bounded left shift
`timescale 1ns/1ps
`default_nettype none

module fp_normalize import fp_wb_pkg::*; (
    input  logic sign,
    input  expo_t expo,
    input  frac_t frac,
    input  shift_amt_t clz,
    input  logic hidden,
    input  logic safe,
    input  logic carry,
    input  grs_t grs,
    output logic sign_norm,
    output expo_t expo_norm,
    output frac_t frac_norm,
    output grs_t grs_norm,
    output logic overflow_before_rounding
);

    // Fraction, safe bit, then guard/round/sticky
    logic [FRAC_WIDTH+3:0] frac_string;
    logic [FRAC_WIDTH+3:0] frac_shifted;
    expo_t shift_limit;
    logic limit_hit;
    shift_amt_t shift_amt;
    // One spare bit catches exponent wrap
    logic [EXPO_WIDTH:0] expo_wide;

    //////////////////////////////
    // Left shift bound

    // Never shift past exponent 1
    always_comb begin
        shift_limit = (expo == '0) ? '0 : expo - expo_t'(1);
        limit_hit = expo_t'(clz) > shift_limit;
        // Limit fits, as it is below clz here
        shift_amt = limit_hit ? shift_amt_t'(shift_limit) : clz;
    end

    assign frac_string = {frac, safe, grs};
    // Zero fill from the right
    assign frac_shifted = frac_string << shift_amt;

    //////////////////////////////
    // Select shift direction

    always_comb begin
        if (carry) begin
            // Mantissa grew to 2.x, move right one
            frac_norm = {hidden, frac[FRAC_WIDTH-1:1]};
            grs_norm = {frac[0], grs[2], grs[1] | grs[0]};
            expo_wide = {1'b0, expo} + (EXPO_WIDTH+1)'(1);
        end else begin
            frac_norm = frac_shifted[FRAC_WIDTH+3:4];
            // Guard and round, then the rest folds into sticky
            grs_norm = {frac_shifted[3], frac_shifted[2], |frac_shifted[1:0]};
            // Bounded shift lands in the subnormal range
            if (limit_hit) begin
                expo_wide = '0;
            end else begin
                expo_wide = {1'b0, expo} - (EXPO_WIDTH+1)'(clz);
            end
        end
    end

    assign sign_norm = sign;
    assign expo_norm = expo_wide[EXPO_WIDTH-1:0];
    // Already at infinity exponent before any rounding
    assign overflow_before_rounding = expo_wide >= (EXPO_WIDTH+1)'(EXPO_MAX);

endmodule

`default_nettype wire

//--- hdl/fp_round_decision.sv
// Round-up decision per rounding mode and the result to use on overflow
`timescale 1ns/1ps
`default_nettype none

module fp_round_decision import fp_wb_pkg::*; (
    input  logic sign,
    input  logic lsb,
    input  rm_t rm,
    input  grs_t grs,
    output logic roundup,
    output fp_word_t result_if_overflow
);

    logic inexact;
    logic to_max_finite;

    assign inexact = |grs;

    //////////////////////////////
    // Round-up per mode

    always_comb begin
        case (rm)
            // Ties go to the even neighbour
            RM_RNE: roundup = grs[2] & (grs[1] | grs[0] | lsb);
            RM_RTZ: roundup = 1'b0;
            // Toward minus infinity grows negative magnitudes
            RM_RDN: roundup = sign & inexact;
            RM_RUP: roundup = ~sign & inexact;
            // Ties away from zero
            RM_RMM: roundup = grs[2];
            default: roundup = 1'b0;
        endcase
    end

    //////////////////////////////
    // Overflow value

    // Modes rounding toward zero magnitude clamp to max finite
    assign to_max_finite = (rm == RM_RTZ) |
                           ((rm == RM_RDN) & ~sign) |
                           ((rm == RM_RUP) & sign);

    always_comb begin
        if (to_max_finite) begin
            // Exponent 254, fraction all ones
            result_if_overflow = {sign, expo_t'(EXPO_MAX - 1), {FRAC_WIDTH{1'b1}}};
        end else begin
            result_if_overflow = {sign, expo_t'(EXPO_MAX), {FRAC_WIDTH{1'b0}}};
        end
    end

endmodule

`default_nettype wire

//--- hdl/fp_round_stage.sv
// Stage-2 register, mantissa increment, final flags and the snoop copy
`timescale 1ns/1ps
`default_nettype none

module fp_round_stage import fp_wb_pkg::*; (
    input  logic clk,
    input  logic rst,
    // Normalized packet from stage 1
    input  logic in_valid,
    input  id_t in_id,
    input  logic in_sign,
    input  expo_t in_expo,
    input  frac_t in_frac,
    input  logic in_roundup,
    input  logic in_overflow_before_rounding,
    input  fp_word_t in_result_if_overflow,
    input  fflags_t in_fflags,
    // Register file result
    output logic wb_valid,
    output id_t wb_id,
    output fp_word_t wb_data,
    // Flag CSR update
    output logic flags_valid,
    output id_t flags_id,
    output fflags_t flags,
    // Store forwarding copy
    output logic snoop_valid,
    output id_t snoop_id,
    output fp_word_t snoop_data
);

    // Stage-2 register
    logic s2_valid;
    id_t s2_id;
    logic s2_sign;
    expo_t s2_expo;
    frac_t s2_frac;
    logic s2_roundup;
    logic s2_overflow_before_rounding;
    fp_word_t s2_result_if_overflow;
    fflags_t s2_fflags;

    // Rounding datapath
    logic [FRAC_WIDTH+1:0] mant_sum;
    logic mant_carry;
    frac_t frac_out;
    logic [EXPO_WIDTH:0] expo_sum;
    expo_t expo_out;
    logic overflow;
    logic underflow;
    fflags_t flags_raised;

    //////////////////////////////
    // Stage-2 register

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_id <= in_id;
        s2_sign <= in_sign;
        s2_expo <= in_expo;
        s2_frac <= in_frac;
        s2_roundup <= in_roundup;
        s2_overflow_before_rounding <= in_overflow_before_rounding;
        s2_result_if_overflow <= in_result_if_overflow;
        s2_fflags <= in_fflags;
    end

    //////////////////////////////
    // Increment and renormalize

    // Leading one only for normal numbers
    assign mant_sum = {1'b0, |s2_expo, s2_frac} + (FRAC_WIDTH+2)'(s2_roundup);
    assign mant_carry = mant_sum[FRAC_WIDTH+1];
    // 1.111..1 plus one becomes 10.0, move back right
    assign frac_out = mant_carry ? mant_sum[FRAC_WIDTH:1] : mant_sum[FRAC_WIDTH-1:0];
    assign expo_sum = {1'b0, s2_expo} + (EXPO_WIDTH+1)'(mant_carry);
    assign expo_out = expo_sum[EXPO_WIDTH-1:0];

    // Overflow from rounding or carried in from normalization
    assign overflow = (expo_sum >= (EXPO_WIDTH+1)'(EXPO_MAX)) | s2_overflow_before_rounding;
    // Tiny nonzero result
    assign underflow = (expo_out == '0) & (|frac_out);

    always_comb begin
        flags_raised = '0;
        flags_raised[FLAG_OF] = overflow;
        // Overflow is always inexact
        flags_raised[FLAG_NX] = overflow;
        flags_raised[FLAG_UF] = underflow;
    end

    //////////////////////////////
    // Result outputs

    assign wb_valid = s2_valid;
    assign wb_id = s2_id;
    assign wb_data = overflow ? s2_result_if_overflow : {s2_sign, expo_out, frac_out};

    // Invalid results keep the unit's flags as they are
    assign flags_valid = s2_valid;
    assign flags_id = s2_id;
    assign flags = s2_fflags[FLAG_NV] ? s2_fflags : (s2_fflags | flags_raised);

    //////////////////////////////
    // Snoop register

    // One cycle behind writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            snoop_valid <= 1'b0;
        end else begin
            snoop_valid <= wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        snoop_id <= wb_id;
        snoop_data <= wb_data;
    end

endmodule

`default_nettype wire

//--- hdl/fp_writeback.sv
// FPU writeback top, arbitration into one shared normalize and round pipeline
`timescale 1ns/1ps
`default_nettype none

module fp_writeback import fp_wb_pkg::*; (
    input  logic clk,
    input  logic rst,
    // Execution unit results
    input  logic [NUM_WB_UNITS-1:0] unit_done,
    input  id_t unit_id [NUM_WB_UNITS],
    input  fp_word_t unit_rd [NUM_WB_UNITS],
    input  rm_t unit_rm [NUM_WB_UNITS],
    input  fflags_t unit_fflags [NUM_WB_UNITS],
    input  shift_amt_t unit_clz [NUM_WB_UNITS],
    input  logic unit_carry [NUM_WB_UNITS],
    input  logic unit_hidden [NUM_WB_UNITS],
    input  logic unit_safe [NUM_WB_UNITS],
    input  grs_t unit_grs [NUM_WB_UNITS],
    output logic [NUM_WB_UNITS-1:0] unit_ack,
    // Writeback, flags and snoop
    output logic wb_valid,
    output id_t wb_id,
    output fp_word_t wb_data,
    output logic flags_valid,
    output id_t flags_id,
    output fflags_t flags,
    output logic snoop_valid,
    output id_t snoop_id,
    output fp_word_t snoop_data
);

    // Stage 1
    logic norm_valid;
    id_t norm_id;
    fp_word_t norm_data;
    rm_t norm_rm;
    fflags_t norm_fflags;
    shift_amt_t norm_clz;
    logic norm_carry;
    logic norm_hidden;
    logic norm_safe;
    grs_t norm_grs;

    // Normalized value and round decision
    logic sign_norm;
    expo_t expo_norm;
    frac_t frac_norm;
    grs_t grs_norm;
    logic overflow_before_rounding;
    logic roundup;
    fp_word_t result_if_overflow;
    fflags_t round_fflags;

    //////////////////////////////
    // Arbitration

    fp_wb_arbiter fp_wb_arbiter_inst (
        .clk (clk),
        .rst (rst),
        .unit_done (unit_done),
        .unit_id (unit_id),
        .unit_rd (unit_rd),
        .unit_rm (unit_rm),
        .unit_fflags (unit_fflags),
        .unit_clz (unit_clz),
        .unit_carry (unit_carry),
        .unit_hidden (unit_hidden),
        .unit_safe (unit_safe),
        .unit_grs (unit_grs),
        .unit_ack (unit_ack),
        .norm_valid (norm_valid),
        .norm_id (norm_id),
        .norm_data (norm_data),
        .norm_rm (norm_rm),
        .norm_fflags (norm_fflags),
        .norm_clz (norm_clz),
        .norm_carry (norm_carry),
        .norm_hidden (norm_hidden),
        .norm_safe (norm_safe),
        .norm_grs (norm_grs)
    );

    //////////////////////////////
    // Normalize and decide

    // Unpack sign, exponent, fraction
    fp_normalize fp_normalize_inst (
        .sign (norm_data[FLEN-1]),
        .expo (norm_data[FLEN-2 -: EXPO_WIDTH]),
        .frac (norm_data[FRAC_WIDTH-1:0]),
        .clz (norm_clz),
        .hidden (norm_hidden),
        .safe (norm_safe),
        .carry (norm_carry),
        .grs (norm_grs),
        .sign_norm (sign_norm),
        .expo_norm (expo_norm),
        .frac_norm (frac_norm),
        .grs_norm (grs_norm),
        .overflow_before_rounding (overflow_before_rounding)
    );

    fp_round_decision fp_round_decision_inst (
        .sign (sign_norm),
        .lsb (frac_norm[0]),
        .rm (norm_rm),
        .grs (grs_norm),
        .roundup (roundup),
        .result_if_overflow (result_if_overflow)
    );

    // Lost bits after normalization mean inexact
    assign round_fflags = norm_fflags | (fflags_t'(|grs_norm) << FLAG_NX);

    //////////////////////////////
    // Round and publish

    fp_round_stage fp_round_stage_inst (
        .clk (clk),
        .rst (rst),
        .in_valid (norm_valid),
        .in_id (norm_id),
        .in_sign (sign_norm),
        .in_expo (expo_norm),
        .in_frac (frac_norm),
        .in_roundup (roundup),
        .in_overflow_before_rounding (overflow_before_rounding),
        .in_result_if_overflow (result_if_overflow),
        .in_fflags (round_fflags),
        .wb_valid (wb_valid),
        .wb_id (wb_id),
        .wb_data (wb_data),
        .flags_valid (flags_valid),
        .flags_id (flags_id),
        .flags (flags),
        .snoop_valid (snoop_valid),
        .snoop_id (snoop_id),
        .snoop_data (snoop_data)
    );

endmodule

`default_nettype wire

//--- tb/fp_writeback_vectors.svh
// Stimulus table for the writeback testbench with one unit result per row and its expected outcome
`ifndef FP_WRITEBACK_VECTORS_SVH
`define FP_WRITEBACK_VECTORS_SVH

// Column order is name, group, unit, rd, rm, fflags, clz, carry, hidden, safe, grs,
//          then expected word and expected flags
// Row number is also the instruction id

task automatic load_vectors();
    //////////////////////////////
    // Exact results in every mode
    add_row("exact_rne", 0, 0, 32'h3fc00000, RM_RNE, 5'h00, 5'd0, 1'b0, 1'b1, 1'b0, 3'b000,
            32'h3fc00000, 5'h00);
    // All four units at once in reverse row order
    add_row("exact_rtz", 1, 3, 32'hc0490fdb, RM_RTZ, 5'h00, 5'd0, 1'b0, 1'b1, 1'b0, 3'b000,
            32'hc0490fdb, 5'h00);
    add_row("exact_rdn", 1, 2, 32'h42f60000, RM_RDN, 5'h00, 5'd0, 1'b0, 1'b1, 1'b0, 3'b000,
            32'h42f60000, 5'h00);
    add_row("exact_rup", 1, 1, 32'hbf800000, RM_RUP, 5'h00, 5'd0, 1'b0, 1'b1, 1'b0, 3'b000,
            32'hbf800000, 5'h00);
    add_row("exact_rmm", 1, 0, 32'h7f7fffff, RM_RMM, 5'h00, 5'd0, 1'b0, 1'b1, 1'b0, 3'b000,
            32'h7f7fffff, 5'h00);

    //////////////////////////////
    // Normalization
    // Shift by 3 takes expo 130 down to 127
    add_row("lshift_3", 2, 1, 32'h410a0000, RM_RNE, 5'h00, 5'd3, 1'b0, 1'b1, 1'b1, 3'b010,
            32'h3fd00005, 5'h00);
    // clz 12 bounded to 2 lands subnormal
    add_row("lshift_subn", 2, 2, 32'h01800400, RM_RNE, 5'h00, 5'd12, 1'b0, 1'b1, 1'b0, 3'b000,
            32'h00001000, 5'h02);

    //////////////////////////////
    // Inexact rounding
    // Carry shift leaves a tie and the even lsb stays
    add_row("rne_tie", 3, 0, 32'h3fc00001, RM_RNE, 5'h00, 5'd0, 1'b1, 1'b1, 1'b0, 3'b000,
            32'h40600000, 5'h01);
    // All-ones fraction carries into the exponent
    add_row("rne_carry", 3, 3, 32'h3fffffff, RM_RNE, 5'h00, 5'd0, 1'b0, 1'b1, 1'b1, 3'b100,
            32'h40000000, 5'h01);
    add_row("rtz_inexact", 4, 2, 32'h3f800000, RM_RTZ, 5'h00, 5'd0, 1'b0, 1'b1, 1'b1, 3'b111,
            32'h3f800000, 5'h01);
    add_row("rdn_neg", 4, 1, 32'hbf800000, RM_RDN, 5'h00, 5'd0, 1'b0, 1'b1, 1'b0, 3'b001,
            32'hbf800001, 5'h01);
    add_row("rup_pos", 5, 3, 32'h40400000, RM_RUP, 5'h00, 5'd0, 1'b0, 1'b1, 1'b0, 3'b010,
            32'h40400001, 5'h01);
    add_row("rmm_tie", 5, 0, 32'h3f800002, RM_RMM, 5'h00, 5'd0, 1'b0, 1'b1, 1'b1, 3'b000,
            32'h3f800003, 5'h01);

    //////////////////////////////
    // Overflow and invalid
    add_row("ovf_rne_inf", 6, 1, 32'h7f7fffff, RM_RNE, 5'h00, 5'd0, 1'b0, 1'b1, 1'b1, 3'b000,
            32'h7f800000, 5'h05);
    // Carry pushes expo to 255 before rounding
    add_row("ovf_rtz_max", 6, 0, 32'hff7fffff, RM_RTZ, 5'h00, 5'd0, 1'b1, 1'b1, 1'b0, 3'b000,
            32'hff7fffff, 5'h05);
    add_row("nv_pass", 7, 2, 32'h7f000000, RM_RNE, 5'h10, 5'd0, 1'b1, 1'b1, 1'b0, 3'b000,
            32'h7f800000, 5'h10);
endtask

`endif

//--- tb/fp_writeback_tb.sv
// Testbench for the FPU writeback stage with table-driven units and a result scoreboard
`timescale 1ns/1ps
`default_nettype none

module fp_writeback_tb import fp_wb_pkg::*; ();

    logic clk;
    logic rst;
    // Unit side
    logic [NUM_WB_UNITS-1:0] unit_done;
    id_t unit_id [NUM_WB_UNITS];
    fp_word_t unit_rd [NUM_WB_UNITS];
    rm_t unit_rm [NUM_WB_UNITS];
    fflags_t unit_fflags [NUM_WB_UNITS];
    shift_amt_t unit_clz [NUM_WB_UNITS];
    logic unit_carry [NUM_WB_UNITS];
    logic unit_hidden [NUM_WB_UNITS];
    logic unit_safe [NUM_WB_UNITS];
    grs_t unit_grs [NUM_WB_UNITS];
    logic [NUM_WB_UNITS-1:0] unit_ack;
    // Result side
    logic wb_valid;
    id_t wb_id;
    fp_word_t wb_data;
    logic flags_valid;
    id_t flags_id;
    fflags_t flags;
    logic snoop_valid;
    id_t snoop_id;
    fp_word_t snoop_data;

    //////////////////////////////
    // Stimulus table
    string vec_name [$];
    int vec_group [$];
    int vec_unit [$];
    fp_word_t vec_rd [$];
    rm_t vec_rm [$];
    fflags_t vec_fflags [$];
    shift_amt_t vec_clz [$];
    logic vec_carry [$];
    logic vec_hidden [$];
    logic vec_safe [$];
    grs_t vec_grs [$];
    fp_word_t vec_exp_word [$];
    fflags_t vec_exp_flags [$];

    // Scoreboard rows with the cycle each is due
    int unit_row [NUM_WB_UNITS];
    int wb_row_q [$];
    int wb_due_q [$];
    int snoop_row_q [$];
    int snoop_due_q [$];
    int cycle = 0;
    int timeout_cycles;
    int checked_count = 0;
    logic [NUM_WB_UNITS-1:0] expected_ack;
    string ack_name;
    int wb_row;
    int snoop_row;

    fp_writeback fp_writeback_inst (
        .clk (clk), .rst (rst),
        .unit_done (unit_done), .unit_id (unit_id), .unit_rd (unit_rd), .unit_rm (unit_rm),
        .unit_fflags (unit_fflags), .unit_clz (unit_clz), .unit_carry (unit_carry),
        .unit_hidden (unit_hidden), .unit_safe (unit_safe), .unit_grs (unit_grs),
        .unit_ack (unit_ack),
        .wb_valid (wb_valid), .wb_id (wb_id), .wb_data (wb_data),
        .flags_valid (flags_valid), .flags_id (flags_id), .flags (flags),
        .snoop_valid (snoop_valid), .snoop_id (snoop_id), .snoop_data (snoop_data)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input fp_word_t expected, input fp_word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_flags(input string name, input fflags_t expected, input fflags_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic check_id(input string name, input id_t expected, input id_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_ack(input string name, input logic [NUM_WB_UNITS-1:0] expected,
                             input logic [NUM_WB_UNITS-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic add_row(input string name, input int group, input int unit,
                           input fp_word_t rd, input rm_t rm, input fflags_t fflags,
                           input shift_amt_t clz, input logic carry, input logic hidden,
                           input logic safe, input grs_t grs,
                           input fp_word_t exp_word, input fflags_t exp_flags);
        vec_name.push_back(name);
        vec_group.push_back(group);
        vec_unit.push_back(unit);
        vec_rd.push_back(rd);
        vec_rm.push_back(rm);
        vec_fflags.push_back(fflags);
        vec_clz.push_back(clz);
        vec_carry.push_back(carry);
        vec_hidden.push_back(hidden);
        vec_safe.push_back(safe);
        vec_grs.push_back(grs);
        vec_exp_word.push_back(exp_word);
        vec_exp_flags.push_back(exp_flags);
    endtask

    `include "fp_writeback_vectors.svh"

    // Unit raises done with its row's fields
    task automatic present_row(input int r);
        int k;
        k = vec_unit[r];
        unit_row[k] = r;
        unit_id[k] = id_t'(r);
        unit_rd[k] = vec_rd[r];
        unit_rm[k] = vec_rm[r];
        unit_fflags[k] = vec_fflags[r];
        unit_clz[k] = vec_clz[r];
        unit_carry[k] = vec_carry[r];
        unit_hidden[k] = vec_hidden[r];
        unit_safe[k] = vec_safe[r];
        unit_grs[k] = vec_grs[r];
        unit_done[k] = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Cycle count and timeout
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            abort_run($sformatf("Timeout after %0d cycles, results still outstanding", cycle));
        end
    end

    //////////////////////////////
    // Scoreboard sampled mid-cycle
    always @(negedge clk) begin
        // Lowest set done bit
        expected_ack = unit_done & (~unit_done + (NUM_WB_UNITS)'(1));
        ack_name = "idle";
        for (int k = 0; k < NUM_WB_UNITS; k++) begin
            if (expected_ack[k] === 1'b1) begin
                ack_name = vec_name[unit_row[k]];
            end
        end
        check_ack({ack_name, " unit_ack"}, expected_ack, unit_ack);
        for (int k = 0; k < NUM_WB_UNITS; k++) begin
            if (unit_ack[k] === 1'b1) begin
                wb_row_q.push_back(unit_row[k]);
                wb_due_q.push_back(cycle + 2);
            end
        end
        if (wb_valid !== 1'b0) begin
            if (wb_row_q.size() == 0) begin
                abort_run("A writeback result appeared with no accepted request");
            end else begin
                wb_row = wb_row_q.pop_front();
                if (wb_due_q.pop_front() != cycle) begin
                    abort_run($sformatf("Result of %s left at the wrong cycle", vec_name[wb_row]));
                end
                if (flags_valid !== 1'b1) begin
                    abort_run("flags_valid is low while wb_valid is high");
                end
                check_id({vec_name[wb_row], " wb_id"}, id_t'(wb_row), wb_id);
                check_id({vec_name[wb_row], " flags_id"}, id_t'(wb_row), flags_id);
                check_word({vec_name[wb_row], " wb_data"}, vec_exp_word[wb_row], wb_data);
                check_flags({vec_name[wb_row], " flags"}, vec_exp_flags[wb_row], flags);
                snoop_row_q.push_back(wb_row);
                snoop_due_q.push_back(cycle + 1);
            end
        end else if (flags_valid !== 1'b0) begin
            abort_run("flags_valid is high while wb_valid is low");
        end else if (wb_due_q.size() > 0 && wb_due_q[0] <= cycle) begin
            abort_run("An accepted result never reached writeback");
        end
        // Store forwarding copy one cycle behind
        if (snoop_valid !== 1'b0) begin
            if (snoop_row_q.size() == 0) begin
                abort_run("A snoop result appeared with no writeback before it");
            end else begin
                snoop_row = snoop_row_q.pop_front();
                if (snoop_due_q.pop_front() != cycle) begin
                    abort_run($sformatf("Snoop of %s at the wrong cycle", vec_name[snoop_row]));
                end
                check_id({vec_name[snoop_row], " snoop_id"}, id_t'(snoop_row), snoop_id);
                check_word({vec_name[snoop_row], " snoop_data"}, vec_exp_word[snoop_row],
                           snoop_data);
                checked_count++;
            end
        end
    end

    //////////////////////////////
    // Unit emulation group by group
    initial begin
        int last_group;
        logic [NUM_WB_UNITS-1:0] acked;
        rst = 1'b1;
        unit_done = '0;
        for (int k = 0; k < NUM_WB_UNITS; k++) begin
            unit_row[k] = 0;
            unit_id[k] = '0;
            unit_rd[k] = '0;
            unit_rm[k] = RM_RNE;
            unit_fflags[k] = '0;
            unit_clz[k] = '0;
            unit_carry[k] = 1'b0;
            unit_hidden[k] = 1'b0;
            unit_safe[k] = 1'b0;
            unit_grs[k] = '0;
        end
        load_vectors();
        timeout_cycles = vec_name.size() * 4 + 20;
        last_group = 0;
        foreach (vec_group[r]) begin
            if (vec_group[r] > last_group) begin
                last_group = vec_group[r];
            end
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int g = 0; g <= last_group; g++) begin
            @(posedge clk);
            #1;
            for (int r = 0; r < vec_name.size(); r++) begin
                if (vec_group[r] == g) begin
                    present_row(r);
                end
            end
            // Losers keep done and fields until acked
            while (unit_done != '0) begin
                @(negedge clk);
                acked = unit_ack;
                @(posedge clk);
                #1;
                unit_done = unit_done & ~acked;
            end
        end
        while (wb_row_q.size() > 0 || snoop_row_q.size() > 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (checked_count == vec_name.size()) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run($sformatf("Only %0d of %0d results reached the snoop port",
                                checked_count, vec_name.size()));
        end
    end

endmodule

`default_nettype wire

//--- fp_writeback.f
+incdir+tb
hdl/fp_wb_pkg.sv
hdl/fp_wb_arbiter.sv
hdl/fp_normalize.sv
hdl/fp_round_decision.sv
hdl/fp_round_stage.sv
hdl/fp_writeback.sv
tb/fp_writeback_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FPU writeback testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -j 0 --top-module fp_writeback_tb --Mdir obj_dir -f fp_writeback.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vfp_writeback_tb 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
